/* hw/loader_pkg.sv */
// download index 0 only; port 1 takes 0x00000-0x17fff, port 2 takes 0x18000-0x37fff, rest dropped
package loader_pkg;

	// ========================================
	// widths
	// ========================================
	localparam int DL_ADDR_W  = 25;
	localparam int MEM_ADDR_W = 23;
	localparam int BYTE_W     = 8;

	// ========================================
	// download address map
	// ========================================
	// start of the 16-bit CSD sound ROM
	localparam logic [DL_ADDR_W-1:0] CSD_BASE    = 25'h0010000;
	// four sprite ROMs merged into 32-bit words
	localparam logic [DL_ADDR_W-1:0] SPRITE_BASE = 25'h0018000;
	// background and character ROMs start here, not stored
	localparam logic [DL_ADDR_W-1:0] SPRITE_END  = 25'h0038000;

	typedef enum logic {
		PORT1 = 1'b0,
		PORT2 = 1'b1
	} mem_port_e;

	// port-1 layout, word address with the byte lane below it
	typedef struct packed {
		logic [MEM_ADDR_W-1:0] word;
		logic                  lane;
	} rom_view_t;

	// port-2 layout, fields named after the rebased sprite offset bits
	typedef struct packed {
		logic [6:0]  off_hi;
		logic [14:0] off_mid;
		logic        off_b16;
		logic        off_b15;
	} sprite_view_t;

	typedef union packed {
		rom_view_t    rom_view;
		sprite_view_t sprite_view;
	} mem_addr_u;

	typedef struct packed {
		mem_port_e         port;
		mem_addr_u         addr;
		logic [BYTE_W-1:0] data;
	} write_entry_t;

endpackage

/* hw/mem_write_if.sv */
// credit flow only: a sender must never push without a credit in hand, receivers have no stall
interface mem_write_if;

	// one-cycle strobe, entry valid in the same cycle
	logic push;
	loader_pkg::write_entry_t entry;

	// one-cycle pulse per freed slot
	logic credit;

	modport sender (
		output push,
		output entry,
		input  credit
	);

	modport receiver (
		input  push,
		input  entry,
		output credit
	);

endinterface

/* hw/rom_write_mapper.sv */
// strobes with dl_ready_o low are illegal and lost; addresses at 0x38000 and above are discarded
module rom_write_mapper #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic                             clk_sys,
	input  logic                             rst_i,
	input  logic                             dl_active_i,
	input  logic [7:0]                       dl_index_i,
	input  logic                             dl_wr_i,
	input  logic [loader_pkg::DL_ADDR_W-1:0] dl_addr_i,
	input  logic [loader_pkg::BYTE_W-1:0]    dl_data_i,
	output logic                             dl_ready_o,
	mem_write_if.sender                      wr_o
);

	localparam int CRED_W = $clog2(FIFO_DEPTH + 1);

	logic                             wr_last;
	logic                             strobe_rise;
	logic                             in_range;
	logic                             accept;
	logic [loader_pkg::DL_ADDR_W-1:0] sprite_off;
	logic [CRED_W-1:0]                credits;
	logic                             push_q;
	loader_pkg::write_entry_t         next_entry;
	loader_pkg::write_entry_t         entry_q;

	// one write per rising edge of the strobe, index 0 only
	assign strobe_rise = dl_active_i && dl_wr_i && !wr_last && (dl_index_i == 8'd0);
	assign accept      = strobe_rise && in_range && (credits != '0);
	assign dl_ready_o  = (credits != '0);
	assign sprite_off  = dl_addr_i - loader_pkg::SPRITE_BASE;

	// ========================================
	// address decode
	// ========================================
	always_comb begin
		next_entry      = '0;
		next_entry.data = dl_data_i;
		in_range        = 1'b1;
		if (dl_addr_i < loader_pkg::CSD_BASE) begin
			// 8-bit program and sound ROMs, linear
			next_entry.port               = loader_pkg::PORT1;
			next_entry.addr.rom_view.word = dl_addr_i[loader_pkg::MEM_ADDR_W:1];
			next_entry.addr.rom_view.lane = dl_addr_i[0];
		end else if (dl_addr_i < loader_pkg::SPRITE_BASE) begin
			// 16-bit CSD ROM, bit 14 picks the byte lane
			next_entry.port               = loader_pkg::PORT1;
			next_entry.addr.rom_view.word = {dl_addr_i[23:16], dl_addr_i[15], dl_addr_i[13:0]};
			next_entry.addr.rom_view.lane = dl_addr_i[14];
		end else if (dl_addr_i < loader_pkg::SPRITE_END) begin
			// bit 16 becomes the word LSB so two ROM halves share one 32-bit word
			next_entry.port                         = loader_pkg::PORT2;
			next_entry.addr.sprite_view.off_hi  = sprite_off[23:17];
			next_entry.addr.sprite_view.off_mid = sprite_off[14:0];
			next_entry.addr.sprite_view.off_b16 = sprite_off[16];
			next_entry.addr.sprite_view.off_b15 = sprite_off[15];
		end else begin
			in_range = 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			wr_last <= 1'b0;
			push_q  <= 1'b0;
			credits <= CRED_W'(FIFO_DEPTH);
		end else begin
			wr_last <= dl_wr_i;
			push_q  <= accept;
			case ({accept, wr_o.credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			entry_q <= next_entry;
		end
	end

	assign wr_o.push  = push_q;
	assign wr_o.entry = entry_q;

	// returned credits can never exceed what the buffer holds
	a_credit_bound: assert property (@(posedge clk_sys) disable iff (rst_i)
		credits <= CRED_W'(FIFO_DEPTH))
		else $error("credit counter above FIFO_DEPTH");

	a_no_strobe_stalled: assert property (@(posedge clk_sys) disable iff (rst_i)
		strobe_rise |-> dl_ready_o)
		else $error("download strobe while out of credits");

endmodule

/* hw/credit_fifo.sv */
// relies on the upstream credit count, so a push into a full buffer is a protocol error
module credit_fifo #(
	parameter int FIFO_DEPTH = 4
) (
	input  logic          clk_sys,
	input  logic          rst_i,
	mem_write_if.receiver up_i,
	mem_write_if.sender   dn_o
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	loader_pkg::write_entry_t mem [FIFO_DEPTH];
	logic [PTR_W-1:0]         wr_ptr;
	logic [PTR_W-1:0]         rd_ptr;
	logic [CNT_W-1:0]         count;
	logic                     empty;
	logic                     dn_credit;
	logic                     fwd;
	logic                     bypass;
	logic                     store;
	logic                     pop;
	logic                     dn_push_q;
	logic                     up_credit_q;
	loader_pkg::write_entry_t dn_entry_q;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign empty = (count == '0);
	// the writer holds one entry, so one downstream credit
	assign fwd    = dn_credit && (!empty || up_i.push);
	// empty buffer hands the incoming entry straight through
	assign bypass = fwd && empty;
	assign store  = up_i.push && !bypass;
	assign pop    = fwd && !empty;

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			dn_credit   <= 1'b1;
			dn_push_q   <= 1'b0;
			up_credit_q <= 1'b0;
		end else begin
			if (store) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({store, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			dn_credit   <= (dn_credit && !fwd) || dn_o.credit;
			dn_push_q   <= fwd;
			up_credit_q <= fwd;
		end
	end

	// ========================================
	// storage and output register
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (store) begin
			mem[wr_ptr] <= up_i.entry;
		end
		if (fwd) begin
			dn_entry_q <= empty ? up_i.entry : mem[rd_ptr];
		end
	end

	assign dn_o.push   = dn_push_q;
	assign dn_o.entry  = dn_entry_q;
	assign up_i.credit = up_credit_q;

	// mapper credit count must keep pushes off a full buffer
	a_no_push_full: assert property (@(posedge clk_sys) disable iff (rst_i)
		up_i.push |-> (count != CNT_W'(FIFO_DEPTH)))
		else $error("push into full buffer");

endmodule

/* hw/sdram_port_writer.sv */
// one write in flight across both ports; ack inputs must already be in the clk_sys domain
module sdram_port_writer (
	input  logic                              clk_sys,
	input  logic                              rst_i,
	input  logic                              port1_ack_i,
	input  logic                              port2_ack_i,
	mem_write_if.receiver                     wr_i,
	output logic                              port1_req_o,
	output logic [loader_pkg::MEM_ADDR_W-1:0] port1_addr_o,
	output logic [1:0]                        port1_ds_o,
	output logic [15:0]                       port1_data_o,
	output logic                              port2_req_o,
	output logic [loader_pkg::MEM_ADDR_W-1:0] port2_addr_o,
	output logic [1:0]                        port2_ds_o,
	output logic [15:0]                       port2_data_o
);

	// index 0 is port 1, index 1 is port 2
	logic [1:0]                        req_q;
	logic [1:0]                        ack;
	logic [loader_pkg::MEM_ADDR_W-1:0] addr_q [2];
	logic [1:0]                        ds_q [2];
	logic [15:0]                       data_q [2];
	logic                              busy;
	loader_pkg::mem_port_e             cur_port;
	logic                              done;

	assign ack  = {port2_ack_i, port1_ack_i};
	assign done = busy && (ack[cur_port] == req_q[cur_port]);
	// slot is free again in the ack cycle
	assign wr_i.credit = done;

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			req_q    <= 2'b00;
			busy     <= 1'b0;
			cur_port <= loader_pkg::PORT1;
		end else if (wr_i.push) begin
			req_q[wr_i.entry.port] <= ~req_q[wr_i.entry.port];
			busy                   <= 1'b1;
			cur_port               <= wr_i.entry.port;
		end else if (done) begin
			busy <= 1'b0;
		end
	end

	// ds upper bit selects the high byte, data goes out on both halves
	always_ff @(posedge clk_sys) begin
		if (wr_i.push) begin
			addr_q[wr_i.entry.port] <= wr_i.entry.addr.rom_view.word;
			ds_q[wr_i.entry.port]   <= {wr_i.entry.addr.rom_view.lane,
				~wr_i.entry.addr.rom_view.lane};
			data_q[wr_i.entry.port] <= {wr_i.entry.data, wr_i.entry.data};
		end
	end

	assign port1_req_o  = req_q[0];
	assign port1_addr_o = addr_q[0];
	assign port1_ds_o   = ds_q[0];
	assign port1_data_o = data_q[0];
	assign port2_req_o  = req_q[1];
	assign port2_addr_o = addr_q[1];
	assign port2_ds_o   = ds_q[1];
	assign port2_data_o = data_q[1];

	for (genvar p = 0; p < 2; p++) begin : g_hold_check
		a_hold_stable: assert property (@(posedge clk_sys) disable iff (rst_i)
			(req_q[p] != ack[p]) |=> ($stable(addr_q[p]) && $stable(data_q[p])))
			else $error("port %0d address or data changed while request pending", p + 1);
	end

endmodule

/* hw/reset_sequencer.sv */
// game stays in reset until a download has completed; the second pulse is one cycle wide
module reset_sequencer #(
	parameter int RESET_HOLD = 65535
) (
	input  logic clk_sys,
	input  logic rst_i,
	input  logic dl_active_i,
	input  logic reset_req_i,
	output logic core_reset_o
);

	localparam int CNT_W = $clog2(RESET_HOLD + 1);

	logic             dl_active_d;
	logic             rom_loaded;
	logic [CNT_W-1:0] hold_cnt;
	logic             core_reset_q;

	always_ff @(posedge clk_sys) begin
		if (rst_i) begin
			dl_active_d  <= 1'b0;
			rom_loaded   <= 1'b0;
			hold_cnt     <= CNT_W'(RESET_HOLD);
			core_reset_q <= 1'b1;
		end else begin
			dl_active_d <= dl_active_i;
			// download just ended
			if (dl_active_d && !dl_active_i) begin
				rom_loaded <= 1'b1;
			end
			if (reset_req_i || !rom_loaded) begin
				hold_cnt <= CNT_W'(RESET_HOLD);
			end else if (hold_cnt != '0) begin
				hold_cnt <= hold_cnt - 1'b1;
			end
			// the game core needs a second reset once it has run for a while
			core_reset_q <= reset_req_i || !rom_loaded || (hold_cnt == CNT_W'(1));
		end
	end

	assign core_reset_o = core_reset_q;

endmodule

/* hw/rom_loader_top.sv */
// clk_sys only; memory acks must be synchronous to clk_sys and follow the req toggle protocol
module rom_loader_top #(
	parameter int FIFO_DEPTH = 4,
	parameter int RESET_HOLD = 65535
) (
	input  logic                              clk_sys,
	input  logic                              rst_i,
	input  logic                              dl_active_i,
	input  logic [7:0]                        dl_index_i,
	input  logic                              dl_wr_i,
	input  logic [loader_pkg::DL_ADDR_W-1:0]  dl_addr_i,
	input  logic [loader_pkg::BYTE_W-1:0]     dl_data_i,
	input  logic                              reset_req_i,
	input  logic                              port1_ack_i,
	input  logic                              port2_ack_i,
	output logic                              dl_ready_o,
	output logic                              core_reset_o,
	output logic                              port1_req_o,
	output logic [loader_pkg::MEM_ADDR_W-1:0] port1_addr_o,
	output logic [1:0]                        port1_ds_o,
	output logic [15:0]                       port1_data_o,
	output logic                              port2_req_o,
	output logic [loader_pkg::MEM_ADDR_W-1:0] port2_addr_o,
	output logic [1:0]                        port2_ds_o,
	output logic [15:0]                       port2_data_o
);

	mem_write_if map_link ();
	mem_write_if mem_link ();

	// ========================================
	// download to memory path
	// ========================================
	rom_write_mapper #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_mapper (
		.clk_sys    (clk_sys),
		.rst_i      (rst_i),
		.dl_active_i(dl_active_i),
		.dl_index_i (dl_index_i),
		.dl_wr_i    (dl_wr_i),
		.dl_addr_i  (dl_addr_i),
		.dl_data_i  (dl_data_i),
		.dl_ready_o (dl_ready_o),
		.wr_o       (map_link.sender)
	);

	credit_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_fifo (
		.clk_sys(clk_sys),
		.rst_i  (rst_i),
		.up_i   (map_link.receiver),
		.dn_o   (mem_link.sender)
	);

	sdram_port_writer u_writer (
		.clk_sys     (clk_sys),
		.rst_i       (rst_i),
		.port1_ack_i (port1_ack_i),
		.port2_ack_i (port2_ack_i),
		.wr_i        (mem_link.receiver),
		.port1_req_o (port1_req_o),
		.port1_addr_o(port1_addr_o),
		.port1_ds_o  (port1_ds_o),
		.port1_data_o(port1_data_o),
		.port2_req_o (port2_req_o),
		.port2_addr_o(port2_addr_o),
		.port2_ds_o  (port2_ds_o),
		.port2_data_o(port2_data_o)
	);

	// game reset follows the end of the download
	reset_sequencer #(
		.RESET_HOLD(RESET_HOLD)
	) u_reset (
		.clk_sys     (clk_sys),
		.rst_i       (rst_i),
		.dl_active_i (dl_active_i),
		.reset_req_i (reset_req_i),
		.core_reset_o(core_reset_o)
	);

endmodule

/* test/tb_rom_loader.sv */
// one download session on index 0, FIFO_DEPTH 4 and RESET_HOLD 20; memory acks come from a model
module tb_rom_loader;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int FIFO_DEPTH = 4;
	localparam int RESET_HOLD = 20;
	// about 60 writes at up to 12 cycles each, a 30-cycle stall and the reset checks
	localparam int TIMEOUT_CYCLES = 4000;

	typedef struct packed {
		logic                              port;
		logic [loader_pkg::MEM_ADDR_W-1:0] addr;
		logic [1:0]                        ds;
		logic [15:0]                       data;
	} mem_write_t;

	logic                              clk_sys = 1'b0;
	logic                              rst_i = 1'b1;
	logic                              dl_active_i = 1'b0;
	logic [7:0]                        dl_index_i = 8'd0;
	logic                              dl_wr_i = 1'b0;
	logic [loader_pkg::DL_ADDR_W-1:0]  dl_addr_i = '0;
	logic [loader_pkg::BYTE_W-1:0]     dl_data_i = '0;
	logic                              reset_req_i = 1'b0;
	logic [1:0]                        mem_ack = 2'b00;
	logic [1:0]                        mem_req;
	logic                              dl_ready_o;
	logic                              core_reset_o;
	logic [loader_pkg::MEM_ADDR_W-1:0] port1_addr_o;
	logic [loader_pkg::MEM_ADDR_W-1:0] port2_addr_o;
	logic [1:0]                        port1_ds_o;
	logic [1:0]                        port2_ds_o;
	logic [15:0]                       port1_data_o;
	logic [15:0]                       port2_data_o;

	// memory model state
	logic [1:0]  stall = 2'b00;
	logic [1:0]  pending = 2'b00;
	logic [1:0]  req_seen = 2'b00;
	int          delay [2];
	logic [31:0] rng_state = 32'he4d7fc79;
	mem_write_t  expected [$];
	int          errors = 0;
	int          write_errors = 0;
	int          checked = 0;
	int          cycles = 0;

	always #50 clk_sys = ~clk_sys;

	rom_loader_top #(
		.FIFO_DEPTH(FIFO_DEPTH),
		.RESET_HOLD(RESET_HOLD)
	) UUT (
		.clk_sys     (clk_sys),
		.rst_i       (rst_i),
		.dl_active_i (dl_active_i),
		.dl_index_i  (dl_index_i),
		.dl_wr_i     (dl_wr_i),
		.dl_addr_i   (dl_addr_i),
		.dl_data_i   (dl_data_i),
		.reset_req_i (reset_req_i),
		.port1_ack_i (mem_ack[0]),
		.port2_ack_i (mem_ack[1]),
		.dl_ready_o  (dl_ready_o),
		.core_reset_o(core_reset_o),
		.port1_req_o (mem_req[0]),
		.port1_addr_o(port1_addr_o),
		.port1_ds_o  (port1_ds_o),
		.port1_data_o(port1_data_o),
		.port2_req_o (mem_req[1]),
		.port2_addr_o(port2_addr_o),
		.port2_ds_o  (port2_ds_o),
		.port2_data_o(port2_data_o)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		return s ^ (s << 5);
	endfunction

	function automatic void record_error(input string what);
		errors++;
		$display("%s", what);
	endfunction

	// ========================================
	// reference address map
	// ========================================
	function automatic mem_write_t expected_write(input logic [24:0] a, input logic [7:0] d);
		mem_write_t  w;
		logic [24:0] off;
		logic        lane;
		w.data = {d, d};
		if (a < loader_pkg::CSD_BASE) begin
			w.port = 1'b0;
			w.addr = a[23:1];
			lane   = a[0];
		end else if (a < loader_pkg::SPRITE_BASE) begin
			// bit 14 leaves the word address and picks the lane
			w.port = 1'b0;
			w.addr = {a[23:15], a[13:0]};
			lane   = a[14];
		end else begin
			off    = a - loader_pkg::SPRITE_BASE;
			w.port = 1'b1;
			w.addr = {off[23:17], off[14:0], off[16]};
			lane   = off[15];
		end
		w.ds = {lane, ~lane};
		return w;
	endfunction

	function automatic void compare_field(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got == exp) else begin
			write_errors++;
			$display("MISMATCH %s: got %0h expected %0h", name, got, exp);
		end
	endfunction

	task automatic check_request(input int p);
		mem_write_t got;
		mem_write_t exp;
		got.port = p[0];
		got.addr = (p == 0) ? port1_addr_o : port2_addr_o;
		got.ds   = (p == 0) ? port1_ds_o : port2_ds_o;
		got.data = (p == 0) ? port1_data_o : port2_data_o;
		if (expected.size() == 0) begin
			write_errors++;
			$display("port%0d_req_o toggled with no write outstanding", p + 1);
			return;
		end
		exp = expected.pop_front();
		checked++;
		compare_field("request port", 32'(got.port), 32'(exp.port));
		compare_field($sformatf("port%0d_addr_o", p + 1), 32'(got.addr), 32'(exp.addr));
		compare_field($sformatf("port%0d_ds_o", p + 1), 32'(got.ds), 32'(exp.ds));
		compare_field($sformatf("port%0d_data_o", p + 1), 32'(got.data), 32'(exp.data));
	endtask

	// checks each new request, then acks it after a random delay
	always @(posedge clk_sys) begin
		#10;
		for (int p = 0; p < 2; p++) begin
			if (rst_i) begin
				mem_ack[p]  = 1'b0;
				req_seen[p] = 1'b0;
				pending[p]  = 1'b0;
			end else begin
				if (mem_req[p] != req_seen[p]) begin
					req_seen[p] = mem_req[p];
					check_request(p);
				end
				if (mem_req[p] != mem_ack[p] && !pending[p]) begin
					rng_state  = xorshift32(rng_state);
					delay[p]   = int'(rng_state % 32'd5);
					pending[p] = 1'b1;
				end else if (pending[p] && delay[p] > 0) begin
					delay[p]--;
				end else if (pending[p] && !stall[p]) begin
					mem_ack[p]  = mem_req[p];
					pending[p] = 1'b0;
				end
			end
		end
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, %0d writes checked, %0d errors", cycles,
				checked, errors + write_errors);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// game is held in reset for the whole download
	a_reset_in_download: assert property (@(posedge clk_sys) disable iff (rst_i)
		dl_active_i |-> core_reset_o)
		else record_error("core_reset_o low during the download");

	a_reset_values: assert property (@(posedge clk_sys)
		$fell(rst_i) |-> (mem_req == 2'b00 && dl_ready_o && core_reset_o))
		else record_error("outputs not at their reset values after rst_i");

	a_reset_request: assert property (@(posedge clk_sys) disable iff (rst_i)
		reset_req_i |=> core_reset_o)
		else record_error("core_reset_o not high after reset_req_i");

	task automatic step_cycle();
		@(posedge clk_sys);
		#10;
	endtask

	task automatic send_byte(input logic [24:0] addr, input logic [7:0] data,
		input logic [7:0] index, input int hold);
		while (!dl_ready_o) begin
			step_cycle();
		end
		if (index == 8'd0 && addr < loader_pkg::SPRITE_END) begin
			expected.push_back(expected_write(addr, data));
		end
		dl_index_i = index;
		dl_addr_i  = addr;
		dl_data_i  = data;
		dl_wr_i    = 1'b1;
		repeat (hold) step_cycle();
		dl_wr_i = 1'b0;
		step_cycle();
	endtask

	task automatic wait_drain();
		while (expected.size() != 0 || mem_req != mem_ack) begin
			step_cycle();
		end
	endtask

	// ========================================
	// stimulus
	// ========================================
	initial begin
		int issued;
		int n;
		repeat (3) step_cycle();
		rst_i = 1'b0;
		step_cycle();
		dl_active_i = 1'b1;
		// port 1, linear then CSD lanes
		send_byte(25'h0000000, 8'h11, 8'd0, 1);
		send_byte(25'h0000001, 8'h22, 8'd0, 1);
		send_byte(25'h000abcd, 8'h33, 8'd0, 1);
		send_byte(25'h000ffff, 8'h44, 8'd0, 1);
		send_byte(25'h0010000, 8'h55, 8'd0, 1);
		send_byte(25'h0014000, 8'h66, 8'd0, 1);
		send_byte(25'h0017fff, 8'h77, 8'd0, 1);
		// sprite offset bits 15 and 16, dropped bytes between valid ones
		send_byte(25'h0018000, 8'h88, 8'd0, 1);
		send_byte(25'h0020000, 8'h99, 8'd0, 1);
		send_byte(25'h0028000, 8'haa, 8'd0, 1);
		send_byte(25'h0037fff, 8'hbb, 8'd0, 1);
		send_byte(25'h0038000, 8'hcc, 8'd0, 1);
		send_byte(25'h1ffffff, 8'hdd, 8'd0, 1);
		send_byte(25'h0012345, 8'hee, 8'd0, 1);
		repeat (24) begin
			rng_state = xorshift32(rng_state);
			send_byte({7'd0, rng_state[17:0]}, rng_state[31:24], 8'd0, 1);
		end
		// long strobe counts once, other indexes are ignored
		send_byte(25'h0000100, 8'ha5, 8'd0, 6);
		send_byte(25'h0000102, 8'h5a, 8'h02, 1);
		send_byte(25'h0020002, 8'h3c, 8'h01, 3);
		wait_drain();

		// port 1 stops acking until the buffer fills
		stall[0] = 1'b1;
		issued = 0;
		while (dl_ready_o && issued < 2 * FIFO_DEPTH) begin
			send_byte(25'h0000200 + 25'(issued), 8'(issued) ^ 8'hc3, 8'd0, 1);
			issued++;
		end
		assert (!dl_ready_o && issued <= FIFO_DEPTH + 1)
			else record_error($sformatf("dl_ready_o still high after %0d stalled writes", issued));
		repeat (30) step_cycle();
		stall[0] = 1'b0;
		wait_drain();

		// reset sequencing after the download ends
		dl_active_i = 1'b0;
		n = 0;
		do begin
			step_cycle();
			n++;
		end while (core_reset_o && n < 10);
		assert (!core_reset_o && n <= 2)
			else record_error($sformatf("core_reset_o took %0d cycles to fall", n));
		// pulse delay counts on from the end of the download
		do begin
			step_cycle();
			n++;
		end while (!core_reset_o && n < RESET_HOLD + 10);
		assert (n >= RESET_HOLD && n <= RESET_HOLD + 2)
			else record_error($sformatf("second reset pulse %0d cycles after download", n));
		step_cycle();
		assert (!core_reset_o) else record_error("second reset pulse wider than one cycle");
		repeat (RESET_HOLD + 5) begin
			step_cycle();
			assert (!core_reset_o) else record_error("extra reset pulse after the second one");
		end
		reset_req_i = 1'b1;
		step_cycle();
		assert (core_reset_o) else record_error("core_reset_o low with reset_req_i high");
		reset_req_i = 1'b0;
		step_cycle();

		$display("%0d writes checked, %0d errors", checked, errors + write_errors);
		if (errors + write_errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

/* spyhunter_loader.f */
hw/loader_pkg.sv
hw/mem_write_if.sv
hw/rom_write_mapper.sv
hw/credit_fifo.sv
hw/sdram_port_writer.sv
hw/reset_sequencer.sv
hw/rom_loader_top.sv
test/tb_rom_loader.sv

/* Makefile */
.PHONY: simulate clean

simulate:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module tb_rom_loader -f spyhunter_loader.f -o tb_rom_loader
	./obj_dir/tb_rom_loader | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
